//--- riscvPkg.sv
// Shared RV32I types, opcodes and constants; imported by the core and its submodules
package riscvPkg;

   // Major opcodes handled by the core
   typedef enum logic [6:0] {
      OP_LUI    = 7'b0110111,
      OP_AUIPC  = 7'b0010111,
      OP_JAL    = 7'b1101111,
      OP_JALR   = 7'b1100111,
      OP_BRANCH = 7'b1100011,
      OP_LOAD   = 7'b0000011,
      OP_STORE  = 7'b0100011,
      OP_IMM    = 7'b0010011,
      OP_REG    = 7'b0110011
   } opcode_e;

   typedef struct packed {
      logic [6:0] funct7;
      logic [4:0] rs2;
      logic [4:0] rs1;
      logic [2:0] funct3;
      logic [4:0] rd;
      opcode_e    opcode;
   } rType_t;

   typedef struct packed {
      logic [11:0] imm;
      logic [4:0]  rs1;
      logic [2:0]  funct3;
      logic [4:0]  rd;
      opcode_e     opcode;
   } iType_t;

   typedef struct packed {
      logic [6:0] immHi;
      logic [4:0] rs2;
      logic [4:0] rs1;
      logic [2:0] funct3;
      logic [4:0] immLo;
      opcode_e    opcode;
   } sType_t;

   // Branch offset bits are scattered across the word
   typedef struct packed {
      logic       imm12;
      logic [5:0] imm10_5;
      logic [4:0] rs2;
      logic [4:0] rs1;
      logic [2:0] funct3;
      logic [3:0] imm4_1;
      logic       imm11;
      opcode_e    opcode;
   } bType_t;

   typedef struct packed {
      logic [19:0] imm31_12;
      logic [4:0]  rd;
      opcode_e     opcode;
   } uType_t;

   typedef struct packed {
      logic       imm20;
      logic [9:0] imm10_1;
      logic       imm11;
      logic [7:0] imm19_12;
      logic [4:0] rd;
      opcode_e    opcode;
   } jType_t;

   // One instruction word, viewed in each encoding format
   typedef union packed {
      rType_t r;
      iType_t i;
      sType_t s;
      bType_t b;
      uType_t u;
      jType_t j;
   } instr_u;

   typedef enum logic [3:0] {
      ALU_ADD, ALU_SUB, ALU_SLL, ALU_SLT, ALU_SLTU, ALU_XOR,
      ALU_SRL, ALU_SRA, ALU_OR, ALU_AND, ALU_PASSB
   } aluOp_e;

   typedef enum logic [1:0] {
      WB_ALU,
      WB_LOAD,
      WB_LINK
   } wbSel_e;

   typedef struct packed {
      aluOp_e     aluOp;
      logic       srcAPc;
      logic       srcBImm;
      logic       isBranch;
      logic       isJal;
      logic       isJalr;
      logic       memRead;
      logic       memWrite;
      logic [1:0] memSize;
      logic       memUnsigned;
      logic       regWrite;
      wbSel_e     wbSel;
      logic [4:0] rd;
      logic [4:0] rs1;
      logic [4:0] rs2;
      logic [2:0] funct3;
   } ctrl_t;

   typedef struct packed {
      logic [31:0] address;
      logic [3:0]  byteEnable;
      logic [31:0] data;
   } memWrite_t;

   // ADDI x0, x0, 0
   localparam logic [31:0] NOP_INSTR = 32'h0000_0013;

endpackage

//--- instrDecoder.sv
// Execute-stage decoder; turns one instruction word into control fields and its immediate
module instrDecoder (
   input  riscvPkg::instr_u instr,
   output riscvPkg::ctrl_t  ctrl,
   output logic [31:0]      imm
);
   import riscvPkg::*;

   // funct7 bit 5 selects SUB and SRA; SUB only exists in register form
   function automatic aluOp_e aluFromFunct(input logic [2:0] f3, input logic alt,
                                           input logic isReg);
      aluOp_e op;
      case (f3)
         3'b000:  op = (isReg && alt) ? ALU_SUB : ALU_ADD;
         3'b001:  op = ALU_SLL;
         3'b010:  op = ALU_SLT;
         3'b011:  op = ALU_SLTU;
         3'b100:  op = ALU_XOR;
         3'b101:  op = alt ? ALU_SRA : ALU_SRL;
         3'b110:  op = ALU_OR;
         default: op = ALU_AND;
      endcase
      return op;
   endfunction

   always_comb
   begin
      // Register fields sit in the same place in every format
      ctrl             = '0;
      ctrl.aluOp       = ALU_ADD;
      ctrl.wbSel       = WB_ALU;
      ctrl.rd          = instr.r.rd;
      ctrl.rs1         = instr.r.rs1;
      ctrl.rs2         = instr.r.rs2;
      ctrl.funct3      = instr.r.funct3;
      ctrl.memSize     = instr.r.funct3[1:0];
      ctrl.memUnsigned = instr.r.funct3[2];
      imm              = '0;

      case (instr.r.opcode)
         OP_LUI:
         begin
            imm          = {instr.u.imm31_12, 12'b0};
            ctrl.aluOp   = ALU_PASSB;
            ctrl.srcBImm = 1'b1;
            ctrl.regWrite = 1'b1;
         end
         OP_AUIPC:
         begin
            imm          = {instr.u.imm31_12, 12'b0};
            ctrl.srcAPc  = 1'b1;
            ctrl.srcBImm = 1'b1;
            ctrl.regWrite = 1'b1;
         end
         OP_JAL:
         begin
            imm = {{11{instr.j.imm20}}, instr.j.imm20, instr.j.imm19_12,
                   instr.j.imm11, instr.j.imm10_1, 1'b0};
            ctrl.isJal    = 1'b1;
            ctrl.regWrite = 1'b1;
            ctrl.wbSel    = WB_LINK;
         end
         OP_JALR:
         begin
            imm           = {{20{instr.i.imm[11]}}, instr.i.imm};
            ctrl.isJalr   = 1'b1;
            ctrl.srcBImm  = 1'b1;
            ctrl.regWrite = 1'b1;
            ctrl.wbSel    = WB_LINK;
         end
         OP_BRANCH:
         begin
            imm = {{19{instr.b.imm12}}, instr.b.imm12, instr.b.imm11,
                   instr.b.imm10_5, instr.b.imm4_1, 1'b0};
            ctrl.isBranch = 1'b1;
         end
         OP_LOAD:
         begin
            imm           = {{20{instr.i.imm[11]}}, instr.i.imm};
            ctrl.srcBImm  = 1'b1;
            ctrl.memRead  = 1'b1;
            ctrl.regWrite = 1'b1;
            ctrl.wbSel    = WB_LOAD;
         end
         OP_STORE:
         begin
            imm           = {{20{instr.s.immHi[6]}}, instr.s.immHi, instr.s.immLo};
            ctrl.srcBImm  = 1'b1;
            ctrl.memWrite = 1'b1;
         end
         OP_IMM:
         begin
            imm           = {{20{instr.i.imm[11]}}, instr.i.imm};
            ctrl.aluOp    = aluFromFunct(instr.i.funct3, instr.r.funct7[5], 1'b0);
            ctrl.srcBImm  = 1'b1;
            ctrl.regWrite = 1'b1;
         end
         OP_REG:
         begin
            ctrl.aluOp    = aluFromFunct(instr.r.funct3, instr.r.funct7[5], 1'b1);
            ctrl.regWrite = 1'b1;
         end
         default:
         begin
            // FENCE, SYSTEM and unknown words retire as NOPs
            ctrl.regWrite = 1'b0;
         end
      endcase
   end

endmodule

//--- alu.sv
// Integer ALU with branch compare; combinational, used in the execute stage
module alu (
   input  logic [31:0]      a,
   input  logic [31:0]      b,
   input  riscvPkg::aluOp_e op,
   input  logic [2:0]       funct3,
   output logic [31:0]      result,
   output logic             branchTaken
);
   import riscvPkg::*;

   logic        isEqual;
   logic        lessSigned;
   logic        lessUnsigned;
   logic [4:0]  shamt;

   assign isEqual      = (a == b);
   assign lessSigned   = ($signed(a) < $signed(b));
   assign lessUnsigned = (a < b);
   assign shamt        = b[4:0];

   always_comb
   begin
      case (op)
         ALU_ADD:   result = a + b;
         ALU_SUB:   result = a - b;
         ALU_SLL:   result = a << shamt;
         ALU_SLT:   result = {31'b0, lessSigned};
         ALU_SLTU:  result = {31'b0, lessUnsigned};
         ALU_XOR:   result = a ^ b;
         ALU_SRL:   result = a >> shamt;
         ALU_SRA:   result = $unsigned($signed(a) >>> shamt);
         ALU_OR:    result = a | b;
         ALU_AND:   result = a & b;
         ALU_PASSB: result = b;
         default:   result = a + b;
      endcase
   end

   // BEQ, BNE, BLT, BGE, BLTU, BGEU
   always_comb
   begin
      case (funct3)
         3'b000:  branchTaken = isEqual;
         3'b001:  branchTaken = !isEqual;
         3'b100:  branchTaken = lessSigned;
         3'b101:  branchTaken = !lessSigned;
         3'b110:  branchTaken = lessUnsigned;
         3'b111:  branchTaken = !lessUnsigned;
         default: branchTaken = 1'b0;
      endcase
   end

endmodule

//--- regFile.sv
// Integer register file, two asynchronous reads and one clocked write; x0 is hardwired
module regFile (
   input  logic        clk,
   input  logic        we,
   input  logic [4:0]  ra1,
   input  logic [4:0]  ra2,
   input  logic [4:0]  wa,
   input  logic [31:0] wd,
   output logic [31:0] rd1,
   output logic [31:0] rd2
);

   logic [31:0] regs [32];

   always_ff @(posedge clk)
   begin
      if (we && (wa != 5'd0))
      begin
         regs[wa] <= wd;
      end
   end

   // x0 never stored, so read it as constant zero
   assign rd1 = (ra1 == 5'd0) ? 32'd0 : regs[ra1];
   assign rd2 = (ra2 == 5'd0) ? 32'd0 : regs[ra2];

endmodule

//--- loadStoreAlign.sv
// Byte-lane steering for the data port; store side in execute, load side in writeback
module loadStoreAlign (
   input  logic [31:0]         storeData,
   input  logic [31:0]         storeAddr,
   input  logic [1:0]          storeSize,
   input  logic                storeEn,
   output riscvPkg::memWrite_t storeWord,
   input  logic [31:0]         loadWord,
   input  logic [1:0]          loadOffset,
   input  logic [1:0]          loadSize,
   input  logic                loadUnsigned,
   output logic [31:0]         loadData
);

   logic [31:0] loadShifted;

   // Store: replicate the value in every lane, enable only the addressed ones
   always_comb
   begin
      storeWord.address = {storeAddr[31:2], 2'b00};
      case (storeSize)
         2'd0:
         begin
            storeWord.data       = {4{storeData[7:0]}};
            storeWord.byteEnable = 4'b0001 << storeAddr[1:0];
         end
         2'd1:
         begin
            storeWord.data       = {2{storeData[15:0]}};
            storeWord.byteEnable = 4'b0011 << {storeAddr[1], 1'b0};
         end
         default:
         begin
            storeWord.data       = storeData;
            storeWord.byteEnable = 4'b1111;
         end
      endcase
      if (!storeEn)
      begin
         storeWord.byteEnable = 4'b0000;
      end
   end

   // Load: bring the addressed lane down to bit 0
   assign loadShifted = loadWord >> {loadOffset, 3'b000};

   always_comb
   begin
      case (loadSize)
         2'd0:
         begin
            if (loadUnsigned)
               loadData = {24'd0, loadShifted[7:0]};
            else
               loadData = {{24{loadShifted[7]}}, loadShifted[7:0]};
         end
         2'd1:
         begin
            if (loadUnsigned)
               loadData = {16'd0, loadShifted[15:0]};
            else
               loadData = {{16{loadShifted[15]}}, loadShifted[15:0]};
         end
         default:
         begin
            loadData = loadWord;
         end
      endcase
   end

endmodule

//--- riscvCore.sv
// Three-stage RV32I core (fetch, execute, writeback); top level with external memory ports
module riscvCore #(
   parameter logic [31:0] RESET_VECTOR = 32'h0000_1000
) (
   input  logic                clk,
   input  logic                rst,
   input  logic                stall,
   input  riscvPkg::instr_u    instruction,
   input  logic [31:0]         dmemRdata,
   output logic [31:0]         imemAddr,
   output riscvPkg::memWrite_t dmemWr,
   output logic [31:0]         dmemAddr,
   output logic                dmemRe
);
   import riscvPkg::*;

   // Fetch
   logic [31:0] pc;
   logic [31:0] nextPc;

   // Execute
   logic [31:0] execPc;
   logic        execBubble;
   instr_u      execInstr;
   ctrl_t       ctrl;
   logic [31:0] imm;
   logic [31:0] rd1;
   logic [31:0] rd2;
   logic [31:0] fwdA;
   logic [31:0] fwdB;
   logic [31:0] aluA;
   logic [31:0] aluB;
   logic [31:0] aluResult;
   logic        branchTaken;
   logic        redirect;
   logic [31:0] target;

   // Writeback
   ctrl_t       wbCtrl;
   logic [31:0] wbAluResult;
   logic [31:0] wbLink;
   logic [31:0] loadData;
   logic [31:0] wbResult;

   assign imemAddr = pc;

   // Slot after a redirect, or right after reset, executes as a NOP
   always_comb
   begin
      if (execBubble)
         execInstr = NOP_INSTR;
      else
         execInstr = instruction;
   end

   instrDecoder decoder_i (
      .instr (execInstr),
      .ctrl  (ctrl),
      .imm   (imm)
   );

   regFile regFile_i (
      .clk (clk),
      .we  (wbCtrl.regWrite && !stall),
      .ra1 (ctrl.rs1),
      .ra2 (ctrl.rs2),
      .wa  (wbCtrl.rd),
      .wd  (wbResult),
      .rd1 (rd1),
      .rd2 (rd2)
   );

   // Bypass from writeback, covers load results too
   always_comb
   begin
      fwdA = rd1;
      fwdB = rd2;
      if (wbCtrl.regWrite && (wbCtrl.rd != 5'd0))
      begin
         if (wbCtrl.rd == ctrl.rs1)
            fwdA = wbResult;
         if (wbCtrl.rd == ctrl.rs2)
            fwdB = wbResult;
      end
   end

   assign aluA = ctrl.srcAPc ? execPc : fwdA;
   assign aluB = ctrl.srcBImm ? imm : fwdB;

   alu alu_i (
      .a           (aluA),
      .b           (aluB),
      .op          (ctrl.aluOp),
      .funct3      (ctrl.funct3),
      .result      (aluResult),
      .branchTaken (branchTaken)
   );

   // JALR target comes from the ALU sum with bit 0 dropped
   assign redirect = ctrl.isJal || ctrl.isJalr || (ctrl.isBranch && branchTaken);
   assign target   = ctrl.isJalr ? {aluResult[31:1], 1'b0} : execPc + imm;
   assign nextPc   = redirect ? target : pc + 32'd4;

   loadStoreAlign lsAlign_i (
      .storeData    (fwdB),
      .storeAddr    (aluResult),
      .storeSize    (ctrl.memSize),
      .storeEn      (ctrl.memWrite),
      .storeWord    (dmemWr),
      .loadWord     (dmemRdata),
      .loadOffset   (wbAluResult[1:0]),
      .loadSize     (wbCtrl.memSize),
      .loadUnsigned (wbCtrl.memUnsigned),
      .loadData     (loadData)
   );

   assign dmemRe   = ctrl.memRead;
   assign dmemAddr = dmemWr.address;

   always_comb
   begin
      case (wbCtrl.wbSel)
         WB_LOAD: wbResult = loadData;
         WB_LINK: wbResult = wbLink;
         default: wbResult = wbAluResult;
      endcase
   end

   // Control state
   always_ff @(posedge clk)
   begin
      if (rst)
      begin
         pc         <= RESET_VECTOR;
         execBubble <= 1'b1;
         wbCtrl     <= '0;
      end
      else if (!stall)
      begin
         pc         <= nextPc;
         execBubble <= redirect;
         wbCtrl     <= ctrl;
      end
   end

   // Pipeline payload
   always_ff @(posedge clk)
   begin
      if (!stall)
      begin
         execPc      <= pc;
         wbAluResult <= aluResult;
         wbLink      <= execPc + 32'd4;
      end
   end

endmodule

//--- riscvCore_chk.sv
// Concurrent checks on the core's memory ports; bound into every riscvCore instance
module riscvCore_chk (
   input logic                clk,
   input logic                rst,
   input logic                stall,
   input logic [31:0]         imemAddr,
   input riscvPkg::memWrite_t dmemWr,
   input logic                dmemRe
);

   // Reset leaves a bubble in execute
   assert property (@(posedge clk) rst |=> (dmemWr.byteEnable == 4'b0000 && !dmemRe))
      else $error("memory port active in the cycle after reset");

   assert property (@(posedge clk) disable iff (rst)
                    !(dmemRe && dmemWr.byteEnable != 4'b0000))
      else $error("read and write requested together");

   assert property (@(posedge clk) disable iff (rst) imemAddr[1:0] == 2'b00)
      else $error("fetch address not word aligned");

   assert property (@(posedge clk) disable iff (rst) stall |=> $stable(imemAddr))
      else $error("fetch address moved during stall");

endmodule

bind riscvCore riscvCore_chk chk_i (
   .clk      (clk),
   .rst      (rst),
   .stall    (stall),
   .imemAddr (imemAddr),
   .dmemWr   (dmemWr),
   .dmemRe   (dmemRe)
);

//--- riscvCore_tb.sv
// Testbench for riscvCore: memory models, encoders and directed program tests; run as top module
module riscvCore_tb;
   import riscvPkg::*;

   localparam logic [31:0] RESET_VECTOR = 32'h0000_1000;
   localparam int          NUM_TESTS    = 6;
   localparam int          TEST_CYCLES  = 400;

   logic        clk;
   logic        rst;
   logic        stall;
   instr_u      instruction;
   logic [31:0] dmemRdata;
   logic [31:0] imemAddr;
   memWrite_t   dmemWr;
   logic [31:0] dmemAddr;
   logic        dmemRe;

   logic [31:0] imem [1024];
   logic [31:0] dmem [256];
   memWrite_t   storeQ [$];
   memWrite_t   expQ [$];
   logic [31:0] fetchQ [$];
   int          progIdx;
   int          errorCount;
   logic        stallOn;
   logic [31:0] lfsr;

   // Values seen at the clock edge, applied by the memory models 2 units later
   logic [31:0] edgeFetch;
   logic [31:0] edgeRead;
   logic        edgeRe;
   memWrite_t   edgeWr;
   logic        edgeStall;
   logic        edgeRst;

   riscvCore #(.RESET_VECTOR(RESET_VECTOR)) dut_i (
      .clk         (clk),
      .rst         (rst),
      .stall       (stall),
      .instruction (instruction),
      .dmemRdata   (dmemRdata),
      .imemAddr    (imemAddr),
      .dmemWr      (dmemWr),
      .dmemAddr    (dmemAddr),
      .dmemRe      (dmemRe)
   );

   initial
   begin
      clk = 1'b0;
      forever #10 clk = ~clk;
   end

   // Synchronous memories, updated only on edges without stall
   always @(posedge clk)
   begin
      edgeFetch = imemAddr;
      edgeRead  = dmemAddr;
      edgeRe    = dmemRe;
      edgeWr    = dmemWr;
      edgeStall = stall;
      edgeRst   = rst;
      #2;
      if (!edgeStall)
      begin
         instruction = imem[edgeFetch[11:2]];
         // Read data only defined after a requested read
         if (edgeRe)
            dmemRdata = dmem[edgeRead[9:2]];
         else
            dmemRdata = 'x;
         if (!edgeRst)
         begin
            fetchQ.push_back(edgeFetch);
            if (edgeWr.byteEnable != 4'b0000)
            begin
               for (int i = 0; i < 4; i++)
               begin
                  if (edgeWr.byteEnable[i])
                     dmem[edgeWr.address[9:2]][8*i +: 8] = edgeWr.data[8*i +: 8];
               end
               storeQ.push_back(edgeWr);
            end
         end
      end
   end

   // Galois LFSR, one step per bit taken
   function automatic logic [31:0] lfsrNext(input logic [31:0] s);
      return (s >> 1) ^ (s[0] ? 32'hA300_0000 : 32'h0);
   endfunction

   always @(posedge clk)
   begin
      #2;
      if (stallOn)
      begin
         stall = lfsr[0];
         lfsr  = lfsrNext(lfsr);
         stall = stall & lfsr[0];
         lfsr  = lfsrNext(lfsr);
      end
      else
         stall = 1'b0;
   end

   initial
   begin
      #(NUM_TESTS * TEST_CYCLES * 20);
      $display("timeout: the program never reached its final store");
      $display("=== FAIL ===");
      $fatal(1);
   end

   // Instruction encoders
   function automatic logic [31:0] encR(input logic [6:0] f7, input logic [4:0] rs2,
                                        input logic [4:0] rs1, input logic [2:0] f3,
                                        input logic [4:0] rd);
      return {f7, rs2, rs1, f3, rd, 7'b0110011};
   endfunction

   function automatic logic [31:0] encI(input logic [11:0] imm, input logic [4:0] rs1,
                                        input logic [2:0] f3, input logic [4:0] rd,
                                        input logic [6:0] op);
      return {imm, rs1, f3, rd, op};
   endfunction

   function automatic logic [31:0] encS(input logic [11:0] imm, input logic [4:0] rs2,
                                        input logic [4:0] rs1, input logic [2:0] f3);
      return {imm[11:5], rs2, rs1, f3, imm[4:0], 7'b0100011};
   endfunction

   function automatic logic [31:0] encB(input logic [12:0] imm, input logic [4:0] rs2,
                                        input logic [4:0] rs1, input logic [2:0] f3);
      return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], 7'b1100011};
   endfunction

   function automatic logic [31:0] encU(input logic [19:0] imm, input logic [4:0] rd,
                                        input logic [6:0] op);
      return {imm, rd, op};
   endfunction

   function automatic logic [31:0] encJ(input logic [20:0] imm, input logic [4:0] rd);
      return {imm[20], imm[10:1], imm[11], imm[19:12], rd, 7'b1101111};
   endfunction

   // Reference rules from the RV32I spec
   function automatic logic [31:0] aluRef(input logic [2:0] f3, input logic alt,
                                          input logic [31:0] a, input logic [31:0] b);
      case (f3)
         3'd0:    return alt ? a - b : a + b;
         3'd1:    return a << b[4:0];
         3'd2:    return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
         3'd3:    return (a < b) ? 32'd1 : 32'd0;
         3'd4:    return a ^ b;
         3'd5:    return alt ? $unsigned($signed(a) >>> b[4:0]) : a >> b[4:0];
         3'd6:    return a | b;
         default: return a & b;
      endcase
   endfunction

   function automatic logic branchRef(input logic [2:0] f3, input logic [31:0] a,
                                      input logic [31:0] b);
      case (f3)
         3'd0:    return a == b;
         3'd1:    return a != b;
         3'd4:    return $signed(a) < $signed(b);
         3'd5:    return $signed(a) >= $signed(b);
         3'd6:    return a < b;
         default: return a >= b;
      endcase
   endfunction

   function automatic logic [31:0] pcOf(input int idx);
      return RESET_VECTOR + 32'(4 * idx);
   endfunction

   task automatic reportFail(input string line);
      errorCount++;
      $display("%s", line);
      $display("=== FAIL ===");
      $fatal(1);
   endtask

   // Only enabled byte lanes carry meaning
   task automatic checkStore(input memWrite_t got, input memWrite_t exp);
      logic [31:0] mask;
      for (int i = 0; i < 4; i++)
         mask[8*i +: 8] = {8{exp.byteEnable[i]}};
      if (got.address !== exp.address || got.byteEnable !== exp.byteEnable ||
          (got.data & mask) !== (exp.data & mask))
         reportFail($sformatf("error t=%0t dmemWr got %h expected %h", $time, got, exp));
   endtask

   task automatic checkFetch(input logic [31:0] got, input logic [31:0] exp);
      if (got !== exp)
         reportFail($sformatf("error t=%0t imemAddr got %h expected %h", $time, got, exp));
   endtask

   // Target is fetched two slots after the jump itself
   task automatic checkJumpTarget(input logic [31:0] jumpPc, input logic [31:0] target);
      int idx;
      idx = -1;
      foreach (fetchQ[i])
      begin
         if (idx < 0 && fetchQ[i] == jumpPc)
            idx = i;
      end
      if (idx < 0 || idx + 2 >= fetchQ.size())
         reportFail($sformatf("jump at %h was never followed by two fetches", jumpPc));
      else
         checkFetch(fetchQ[idx + 2], target);
   endtask

   task automatic emit(input logic [31:0] w);
      imem[progIdx] = w;
      progIdx++;
   endtask

   task automatic storeWord(input logic [4:0] rs2, input logic [11:0] addr);
      emit(encS(addr, rs2, 5'd0, 3'b010));
   endtask

   task automatic expectStore(input logic [31:0] addr, input logic [3:0] be,
                              input logic [31:0] data);
      memWrite_t m;
      m.address    = addr;
      m.byteEnable = be;
      m.data       = data;
      expQ.push_back(m);
   endtask

   task automatic loadConst(input logic [4:0] rd, input logic [31:0] v);
      logic [31:0] upper;
      upper = (v + 32'h800) >> 12;
      emit(encU(upper[19:0], rd, OP_LUI));
      emit(encI(v[11:0], rd, 3'b000, rd, OP_IMM));
   endtask

   task automatic startProgram();
      @(posedge clk);
      #2;
      rst     = 1'b1;
      stallOn = 1'b0;
      progIdx = 0;
      expQ.delete();
      for (int i = 0; i < 1024; i++)
         imem[i] = NOP_INSTR;
      for (int i = 0; i < 256; i++)
         dmem[i] = {i[7:0], ~i[7:0], i[7:0] ^ 8'h5A, i[7:0] + 8'hC3};
   endtask

   task automatic runProgram();
      emit(encJ(21'd0, 5'd0));
      repeat (8) @(posedge clk);
      #2;
      storeQ.delete();
      fetchQ.delete();
      rst = 1'b0;
      while (storeQ.size() < expQ.size())
         @(posedge clk);
      repeat (20) @(posedge clk);
      if (storeQ.size() != expQ.size())
         reportFail($sformatf("%0d stores seen where %0d were expected",
                              storeQ.size(), expQ.size()));
      foreach (expQ[i])
         checkStore(storeQ[i], expQ[i]);
   endtask

   task automatic testAlu();
      logic [31:0] a;
      logic [31:0] b;
      logic [11:0] imm;
      logic [11:0] addr;
      a    = 32'hF0F0_1357;
      b    = 32'h0000_0013;
      addr = 12'h100;
      startProgram();
      loadConst(5'd1, a);
      loadConst(5'd2, b);
      for (int f3 = 0; f3 < 8; f3++)
      begin
         for (int alt = 0; alt < 2; alt++)
         begin
            if (alt == 0 || f3 == 0 || f3 == 5)
            begin
               emit(encR(alt ? 7'h20 : 7'h00, 5'd2, 5'd1, 3'(f3), 5'd3));
               storeWord(5'd3, addr);
               expectStore({20'd0, addr}, 4'hF, aluRef(3'(f3), alt[0], a, b));
               addr += 12'd4;
            end
            if (alt == 0 || f3 == 5)
            begin
               if (f3 == 1 || f3 == 5)
                  imm = {alt ? 7'h20 : 7'h00, 5'd7};
               else
                  imm = 12'h8A5;
               emit(encI(imm, 5'd1, 3'(f3), 5'd3, OP_IMM));
               storeWord(5'd3, addr);
               expectStore({20'd0, addr}, 4'hF,
                           aluRef(3'(f3), alt[0], a, {{20{imm[11]}}, imm}));
               addr += 12'd4;
            end
         end
      end
      runProgram();
   endtask

   // Dependent chain, including a load consumed by the next instruction
   task automatic testForward(input logic randomStall);
      logic [31:0] x1;
      logic [31:0] x2;
      logic [31:0] x3;
      logic [31:0] x5;
      startProgram();
      dmem[8'h20] = 32'h0000_0123;
      x1 = 32'd5;
      x2 = x1 + 32'd7;
      x3 = (x2 + x1) * 2;
      x5 = 32'h123 + x3 + 32'd1;
      emit(encI(12'd5, 5'd0, 3'b000, 5'd1, OP_IMM));
      emit(encI(12'd7, 5'd1, 3'b000, 5'd2, OP_IMM));
      emit(encR(7'h00, 5'd1, 5'd2, 3'b000, 5'd3));
      emit(encR(7'h00, 5'd3, 5'd3, 3'b000, 5'd3));
      emit(encI(12'h080, 5'd0, 3'b010, 5'd4, OP_LOAD));
      emit(encR(7'h00, 5'd3, 5'd4, 3'b000, 5'd5));
      emit(encI(12'd1, 5'd5, 3'b000, 5'd5, OP_IMM));
      storeWord(5'd5, 12'h140);
      storeWord(5'd3, 12'h144);
      emit(encR(7'h00, 5'd2, 5'd5, 3'b000, 5'd6));
      storeWord(5'd6, 12'h148);
      emit(encI(12'h080, 5'd0, 3'b010, 5'd7, OP_LOAD));
      storeWord(5'd7, 12'h14C);
      expectStore(32'h140, 4'hF, x5);
      expectStore(32'h144, 4'hF, x3);
      expectStore(32'h148, 4'hF, x5 + x2);
      expectStore(32'h14C, 4'hF, 32'h0000_0123);
      stallOn = randomStall;
      runProgram();
      stallOn = 1'b0;
   endtask

   task automatic testLoadStore();
      logic [31:0] w;
      logic [31:0] sh;
      logic [31:0] res;
      logic [11:0] addr;
      int          step;
      int          sizes [5];
      sizes = '{0, 4, 1, 5, 2};
      w     = 32'h8A7F_F501;
      addr  = 12'h200;
      startProgram();
      dmem[8'h30] = w;
      foreach (sizes[s])
      begin
         step = (sizes[s] % 4 == 0) ? 1 : (sizes[s] % 4 == 1) ? 2 : 4;
         for (int off = 0; off < 4; off += step)
         begin
            sh = w >> (8 * off);
            case (sizes[s])
               0:       res = {{24{sh[7]}}, sh[7:0]};
               4:       res = {24'd0, sh[7:0]};
               1:       res = {{16{sh[15]}}, sh[15:0]};
               5:       res = {16'd0, sh[15:0]};
               default: res = w;
            endcase
            emit(encI(12'h0C0 + 12'(off), 5'd0, 3'(sizes[s]), 5'd8, OP_LOAD));
            storeWord(5'd8, addr);
            expectStore({20'd0, addr}, 4'hF, res);
            addr += 12'd4;
         end
      end
      loadConst(5'd9, 32'hCAFE_BEEF);
      for (int off = 0; off < 4; off++)
      begin
         emit(encS(12'h240 + 12'(off), 5'd9, 5'd0, 3'b000));
         expectStore(32'h240, 4'b0001 << off, {4{8'hEF}});
      end
      for (int off = 0; off < 4; off += 2)
      begin
         emit(encS(12'h250 + 12'(off), 5'd9, 5'd0, 3'b001));
         expectStore(32'h250, 4'b0011 << off, {2{16'hBEEF}});
      end
      runProgram();
   endtask

   task automatic testControl();
      logic [31:0] regs [3];
      logic [31:0] brPc;
      logic [31:0] jalPc;
      logic [31:0] jalrPc;
      logic [2:0]  kinds [6];
      logic [4:0]  pairA [3];
      logic [4:0]  pairB [3];
      logic [11:0] addr;
      kinds = '{3'd0, 3'd1, 3'd4, 3'd5, 3'd6, 3'd7};
      pairA = '{5'd1, 5'd2, 5'd1};
      pairB = '{5'd2, 5'd1, 5'd1};
      regs  = '{32'd0, 32'hFFFF_FFFD, 32'd5};
      brPc  = 32'hFFFF_FFFF;
      addr  = 12'h300;
      startProgram();
      emit(encI(12'hFFD, 5'd0, 3'b000, 5'd1, OP_IMM));
      emit(encI(12'd5, 5'd0, 3'b000, 5'd2, OP_IMM));
      foreach (kinds[k])
      begin
         foreach (pairA[p])
         begin
            if (branchRef(kinds[k], regs[pairA[p]], regs[pairB[p]]) && brPc == 32'hFFFF_FFFF)
               brPc = pcOf(progIdx);
            emit(encB(13'd8, pairB[p], pairA[p], kinds[k]));
            storeWord(5'd1, addr);
            if (!branchRef(kinds[k], regs[pairA[p]], regs[pairB[p]]))
               expectStore({20'd0, addr}, 4'hF, regs[1]);
            addr += 12'd4;
         end
      end
      jalPc = pcOf(progIdx);
      emit(encJ(21'd8, 5'd10));
      storeWord(5'd0, 12'h3F0);
      storeWord(5'd10, 12'h3A0);
      expectStore(32'h3A0, 4'hF, jalPc + 32'd4);
      // Base is two below the target and the offset is 3, so bit 0 must be cleared
      jalrPc = pcOf(progIdx + 2);
      loadConst(5'd11, jalrPc + 32'd8 - 32'd2);
      emit(encI(12'd3, 5'd11, 3'b000, 5'd12, OP_JALR));
      storeWord(5'd0, 12'h3F0);
      storeWord(5'd12, 12'h3A4);
      expectStore(32'h3A4, 4'hF, jalrPc + 32'd4);
      runProgram();
      checkJumpTarget(brPc, brPc + 32'd8);
      checkJumpTarget(jalPc, jalPc + 32'd8);
      checkJumpTarget(jalrPc, jalrPc + 32'd8);
   endtask

   task automatic testUpper();
      logic [31:0] pcA;
      logic [31:0] pcB;
      startProgram();
      emit(encU(20'hABCDE, 5'd13, OP_LUI));
      storeWord(5'd13, 12'h380);
      pcA = pcOf(progIdx);
      emit(encU(20'h12345, 5'd14, OP_AUIPC));
      storeWord(5'd14, 12'h384);
      pcB = pcOf(progIdx);
      emit(encU(20'hFFFFF, 5'd15, OP_AUIPC));
      storeWord(5'd15, 12'h388);
      expectStore(32'h380, 4'hF, {20'hABCDE, 12'd0});
      expectStore(32'h384, 4'hF, {20'h12345, 12'd0} + pcA);
      expectStore(32'h388, 4'hF, {20'hFFFFF, 12'd0} + pcB);
      runProgram();
   endtask

   initial
   begin
      rst         = 1'b1;
      stall       = 1'b0;
      stallOn     = 1'b0;
      instruction = NOP_INSTR;
      dmemRdata   = 32'd0;
      lfsr        = 32'h383c;
      errorCount  = 0;
      testAlu();
      testForward(1'b0);
      testLoadStore();
      testControl();
      testUpper();
      // Same forwarding program under random stall
      testForward(1'b1);
      if (errorCount == 0)
      begin
         $display("=== PASS ===");
         $finish;
      end
      else
      begin
         $display("=== FAIL ===");
         $fatal(1);
      end
   end

endmodule

//--- files.f
riscvPkg.sv
instrDecoder.sv
alu.sv
regFile.sv
loadStoreAlign.sv
riscvCore.sv
riscvCore_chk.sv
riscvCore_tb.sv
